// ==== hdl/icache_consts.svh ====
/*
 * Instruction cache geometry
 * Address split, way count, fetch/bus width and refill burst length
 * for the two-way set-associative instruction cache
 */
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

`define IC_ADDR_W        32   // Physical address bits
`define IC_P_LINE        5    // 32-byte lines
`define IC_P_SETS        4    // 16 sets
`define IC_WAYS          2
`define IC_WORD_W        64   // Fetch word and AXI data width
`define IC_P_WORD_BYTES  3

// Derived geometry
`define IC_SETS          (1 << `IC_P_SETS)
`define IC_P_BEATS       (`IC_P_LINE - `IC_P_WORD_BYTES)
`define IC_BEATS         (1 << `IC_P_BEATS)   // ARLEN is one less
`define IC_TAG_W         (`IC_ADDR_W - `IC_P_SETS - `IC_P_LINE)

`endif

// ==== hdl/icache_pkg.sv ====
/*
 * Instruction cache types
 * Address views, tag entry, RAM command and fetch word
 */
`default_nettype none

package icache_pkg;

`include "icache_consts.svh"

   typedef logic [`IC_WAYS-1:0] ic_way_vec_t;   // Hit vector or victim way

   typedef logic [`IC_WORD_W-1:0] ic_word_t;

   // Lookup view of a fetch address
   typedef struct packed {
      logic [`IC_TAG_W-1:0]        tag;
      logic [`IC_P_SETS-1:0]       set;
      logic [`IC_P_BEATS-1:0]      word;
      logic [`IC_P_WORD_BYTES-1:0] byte_off;
   } ic_addr_fields_t;

   // Bus view, line number plus offset
   typedef struct packed {
      logic [`IC_ADDR_W-`IC_P_LINE-1:0] line;
      logic [`IC_P_LINE-1:0]            offset;
   } ic_addr_line_t;

   typedef union packed {
      ic_addr_fields_t fields;
      ic_addr_line_t   line;
   } ic_addr_u;

   typedef struct packed {
      logic [`IC_TAG_W-1:0] tag;
      logic                 valid;
   } ic_tag_entry_t;

   typedef struct packed {
      logic                              ren;      // Read both RAMs
      ic_way_vec_t                       tag_we;
      logic [`IC_P_SETS-1:0]             tag_set;
      ic_tag_entry_t                     tag_wdata;
      logic [`IC_P_SETS+`IC_P_BEATS-1:0] pay_addr; // {set, word}
      ic_way_vec_t                       pay_we;
   } ic_ram_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/icache_tag_lookup.sv ====
/*
 * Tag lookup stage
 * One tag/valid RAM per way with synchronous read, the stage address
 * and valid registers, and the per-way hit compare
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_tag_lookup (
   input  wire                            clk,
   input  wire                            i_rst_n,
   input  wire                            i_fetch_valid,
   input  wire icache_pkg::ic_addr_u      i_fetch_addr,
   input  wire icache_pkg::ic_ram_cmd_t   i_cmd,
   input  wire                            i_advance,
   output icache_pkg::ic_addr_u           o_s2_addr,
   output logic                           o_s2_valid,
   output icache_pkg::ic_way_vec_t        o_hit_vec
);

   import icache_pkg::*;

   ic_tag_entry_t tag_dout [`IC_WAYS];

   for (genvar w = 0; w < `IC_WAYS; w++)
   begin : g_way
      ic_tag_entry_t tag_mem [`IC_SETS];
      ic_tag_entry_t rd_q;

      always_ff @(posedge clk)
      begin
         if (i_cmd.tag_we[w])
            tag_mem[i_cmd.tag_set] <= i_cmd.tag_wdata;
         else if (i_cmd.ren)
            rd_q <= tag_mem[i_cmd.tag_set]; // Holds while pipeline is stalled
      end

      assign tag_dout[w] = rd_q;
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         o_s2_valid <= 1'b0;
      else if (i_advance)
         o_s2_valid <= i_fetch_valid;
   end

   always_ff @(posedge clk)
   begin
      if (i_advance)
         o_s2_addr <= i_fetch_addr;
   end

   // Compare against the address that was read
   always_comb
   begin
      for (int w = 0; w < `IC_WAYS; w++)
         o_hit_vec[w] = tag_dout[w].valid && (tag_dout[w].tag == o_s2_addr.fields.tag);
   end

endmodule

`default_nettype wire

// ==== hdl/icache_refill_ctrl.sv ====
/*
 * Refill controller
 * Main FSM for boot sweep, lookup, victim replace, AXI line refill,
 * single-line invalidate and tag reload. Drives the RAM command and
 * the AXI AR/R control
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_refill_ctrl (
   input  wire                            clk,
   input  wire                            i_rst_n,
   input  wire icache_pkg::ic_addr_u      i_fetch_addr,
   input  wire icache_pkg::ic_addr_u      i_s2_addr,
   input  wire                            i_s2_valid,
   input  wire icache_pkg::ic_way_vec_t   i_hit_vec,
   input  wire                            i_inv_we,
   input  wire icache_pkg::ic_addr_u      i_inv_addr,
   input  wire                            i_ar_ready,
   input  wire                            i_r_valid,
   input  wire                            i_r_last,
   output icache_pkg::ic_ram_cmd_t        o_cmd,
   output logic                           o_stall,
   output logic                           o_refilling,
   output logic                           o_reloading,
   output logic [`IC_P_BEATS-1:0]         o_beat,
   output logic                           o_r_fire,
   output logic                           o_ar_valid,
   output logic [`IC_ADDR_W-1:0]          o_ar_addr,
   output logic [7:0]                     o_ar_len,
   output logic                           o_r_ready
);

   import icache_pkg::*;

   typedef enum logic [2:0] {
      S_BOOT, S_IDLE, S_REPLACE, S_REFILL, S_INVALIDATE, S_RELOAD
   } state_t;

   state_t                state_q, state_d;
   logic [`IC_P_SETS-1:0] boot_cnt_q;
   ic_way_vec_t           clock_q;   // Rotating one-hot victim pick
   ic_way_vec_t           victim_q;
   ic_addr_u              inv_q;
   ic_addr_line_t         burst_addr;
   logic                  miss;

   assign miss = i_s2_valid && (i_hit_vec == '0);

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         S_BOOT:
            if (boot_cnt_q == `IC_P_SETS'(`IC_SETS - 1))
               state_d = S_IDLE;
         S_IDLE:
            if (i_inv_we)
               state_d = S_INVALIDATE; // Wins over a pending miss
            else if (miss)
               state_d = S_REPLACE;
         S_REPLACE:
            state_d = S_REFILL;
         S_REFILL:
            if (o_r_fire && i_r_last)
               state_d = S_RELOAD;
         default:
            state_d = S_IDLE;   // Invalidate and reload take one cycle
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
      begin
         state_q    <= S_BOOT;
         boot_cnt_q <= '0;
         clock_q    <= ic_way_vec_t'(1);
         victim_q   <= ic_way_vec_t'(1);
         o_beat     <= '0;
      end
      else
      begin
         state_q <= state_d;
         clock_q <= {clock_q[`IC_WAYS-2:0], clock_q[`IC_WAYS-1]};
         if (state_q == S_BOOT)
            boot_cnt_q <= boot_cnt_q + 1'b1;
         if (state_q == S_IDLE && state_d == S_REPLACE)
            victim_q <= clock_q;
         if (state_q == S_REPLACE)
            o_beat <= '0;
         else if (o_r_fire)
            o_beat <= o_beat + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (state_q == S_IDLE && i_inv_we)
         inv_q <= i_inv_addr;
   end

   assign o_stall     = (state_q != S_IDLE) || miss;
   assign o_refilling = (state_q == S_REFILL);
   assign o_reloading = (state_q == S_RELOAD);

   // RAM command per state
   always_comb
   begin
      o_cmd          = '0;
      o_cmd.tag_set  = i_fetch_addr.fields.set;
      o_cmd.pay_addr = {i_fetch_addr.fields.set, i_fetch_addr.fields.word};
      case (state_q)
         S_BOOT:
            begin
               o_cmd.tag_we  = '1;
               o_cmd.tag_set = boot_cnt_q;
            end
         S_IDLE:
            o_cmd.ren = !o_stall;
         S_REPLACE:
            begin
               o_cmd.tag_we    = victim_q;
               o_cmd.tag_set   = i_s2_addr.fields.set;
               o_cmd.tag_wdata = '{tag: i_s2_addr.fields.tag, valid: 1'b1};
            end
         S_REFILL:
            begin
               o_cmd.pay_addr = {i_s2_addr.fields.set, o_beat};
               o_cmd.pay_we   = victim_q & {`IC_WAYS{o_r_fire}};
            end
         S_INVALIDATE:
            begin
               o_cmd.tag_we  = '1;
               o_cmd.tag_set = inv_q.fields.set;
            end
         default:
            begin
               o_cmd.ren      = 1'b1;   // Re-read tags of the held entry
               o_cmd.tag_set  = i_s2_addr.fields.set;
               o_cmd.pay_addr = {i_s2_addr.fields.set, i_s2_addr.fields.word};
            end
      endcase
   end

   // Line-aligned burst start
   always_comb
   begin
      burst_addr        = i_s2_addr.line;
      burst_addr.offset = '0;
   end

   always_ff @(posedge clk)
   begin
      if (!i_rst_n)
         o_ar_valid <= 1'b0;
      else if (state_q == S_REPLACE)
         o_ar_valid <= 1'b1;
      else if (i_ar_ready)
         o_ar_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (state_q == S_REPLACE)
         o_ar_addr <= burst_addr;
   end

   assign o_ar_len  = 8'(`IC_BEATS - 1);
   assign o_r_ready = o_refilling;
   assign o_r_fire  = i_r_valid && o_r_ready;

endmodule

`default_nettype wire

// ==== hdl/icache_payload_result.sv ====
/*
 * Payload store and result stage
 * One payload RAM per way, hit-way select, refill beat forwarding
 * and the registered instruction output
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_payload_result (
   input  wire                            clk,
   input  wire icache_pkg::ic_ram_cmd_t   i_cmd,
   input  wire icache_pkg::ic_word_t      i_r_data,
   input  wire icache_pkg::ic_way_vec_t   i_hit_vec,
   input  wire icache_pkg::ic_addr_u      i_s2_addr,
   input  wire                            i_s2_valid,
   input  wire                            i_stall,
   input  wire                            i_refilling,
   input  wire                            i_reloading,
   input  wire [`IC_P_BEATS-1:0]          i_beat,
   input  wire                            i_r_fire,
   output icache_pkg::ic_word_t           o_ins,
   output logic                           o_ins_valid
);

   import icache_pkg::*;

   ic_word_t pay_dout [`IC_WAYS];
   ic_word_t hit_word;
   logic     pay_ren;
   logic     fwd_hit;
   logic     reload_d;   // First cycle after a refill

   // Reload refreshes tags only, the word is already forwarded
   assign pay_ren = i_cmd.ren && !i_reloading;

   for (genvar w = 0; w < `IC_WAYS; w++)
   begin : g_way
      ic_word_t pay_mem [`IC_SETS*`IC_BEATS];
      ic_word_t rd_q;

      always_ff @(posedge clk)
      begin
         if (i_cmd.pay_we[w])
            pay_mem[i_cmd.pay_addr] <= i_r_data;
         else if (pay_ren)
            rd_q <= pay_mem[i_cmd.pay_addr];
      end

      assign pay_dout[w] = rd_q;
   end

   always_comb
   begin
      hit_word = '0;
      for (int w = 0; w < `IC_WAYS; w++)
         if (i_hit_vec[w])
            hit_word = hit_word | pay_dout[w];
   end

   assign fwd_hit = i_refilling && i_r_fire && (i_beat == i_s2_addr.fields.word);

   always_ff @(posedge clk)
   begin
      reload_d <= i_reloading;
      if (!i_stall)
      begin
         if (!reload_d)   // Keep forwarded word, payload read was stale
            o_ins <= hit_word;
      end
      else if (fwd_hit)
         o_ins <= i_r_data;
   end

   // Clear while stalled, which covers the boot sweep
   always_ff @(posedge clk)
   begin
      o_ins_valid <= i_s2_valid && !i_stall;
   end

endmodule

`default_nettype wire

// ==== hdl/icache_top.sv ====
/*
 * Instruction cache top level
 * Two-way set-associative cache with a two-stage lookup and AXI refill
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_top (
   input  wire                            clk,
   input  wire                            i_rst_n,
   input  wire                            i_fetch_valid,
   input  wire icache_pkg::ic_addr_u      i_fetch_addr,
   output logic                           o_stall,
   output icache_pkg::ic_word_t           o_ins,
   output logic                           o_ins_valid,
   input  wire                            i_inv_we,
   input  wire icache_pkg::ic_addr_u      i_inv_addr,
   output logic                           o_ar_valid,
   output logic [`IC_ADDR_W-1:0]          o_ar_addr,
   output logic [7:0]                     o_ar_len,
   input  wire                            i_ar_ready,
   input  wire                            i_r_valid,
   input  wire icache_pkg::ic_word_t      i_r_data,
   input  wire                            i_r_last,
   output logic                           o_r_ready
);

   import icache_pkg::*;

   ic_ram_cmd_t            cmd;
   ic_addr_u               s2_addr;
   logic                   s2_valid;
   ic_way_vec_t            hit_vec;
   logic                   refilling;
   logic                   reloading;
   logic [`IC_P_BEATS-1:0] beat;
   logic                   r_fire;

   icache_tag_lookup u_lookup (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_fetch_valid (i_fetch_valid),
      .i_fetch_addr  (i_fetch_addr),
      .i_cmd         (cmd),
      .i_advance     (!o_stall),
      .o_s2_addr     (s2_addr),
      .o_s2_valid    (s2_valid),
      .o_hit_vec     (hit_vec)
   );

   icache_refill_ctrl u_ctrl (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_fetch_addr (i_fetch_addr),
      .i_s2_addr    (s2_addr),
      .i_s2_valid   (s2_valid),
      .i_hit_vec    (hit_vec),
      .i_inv_we     (i_inv_we),
      .i_inv_addr   (i_inv_addr),
      .i_ar_ready   (i_ar_ready),
      .i_r_valid    (i_r_valid),
      .i_r_last     (i_r_last),
      .o_cmd        (cmd),
      .o_stall      (o_stall),
      .o_refilling  (refilling),
      .o_reloading  (reloading),
      .o_beat       (beat),
      .o_r_fire     (r_fire),
      .o_ar_valid   (o_ar_valid),
      .o_ar_addr    (o_ar_addr),
      .o_ar_len     (o_ar_len),
      .o_r_ready    (o_r_ready)
   );

   icache_payload_result u_result (
      .clk         (clk),
      .i_cmd       (cmd),
      .i_r_data    (i_r_data),
      .i_hit_vec   (hit_vec),
      .i_s2_addr   (s2_addr),
      .i_s2_valid  (s2_valid),
      .i_stall     (o_stall),
      .i_refilling (refilling),
      .i_reloading (reloading),
      .i_beat      (beat),
      .i_r_fire    (r_fire),
      .o_ins       (o_ins),
      .o_ins_valid (o_ins_valid)
   );

endmodule

`default_nettype wire

// ==== sim/icache_properties.sv ====
/*
 * Refill controller properties
 * AR request stability, R ready held through the refill burst,
 * boot sweep length
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_properties (
   input wire                  clk,
   input wire                  i_rst_n,
   input wire [2:0]            i_state,
   input wire                  i_ar_valid,
   input wire [`IC_ADDR_W-1:0] i_ar_addr,
   input wire                  i_ar_ready,
   input wire                  i_r_valid,
   input wire                  i_r_last,
   input wire                  i_r_ready
);

   localparam logic [2:0] ST_BOOT   = 3'd0;   // FSM encoding of the controller
   localparam logic [2:0] ST_REFILL = 3'd3;

   int fail_cnt = 0;

   ar_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar_addr))
      else
      begin
         fail_cnt++;
         $error("AR request dropped or changed before ready");
      end

   // Ready stays up until the last beat moves, then drops
   r_ready_refill: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_r_ready |-> i_state == ST_REFILL ##1 (i_r_ready == !$past(i_r_valid && i_r_last)))
      else
      begin
         fail_cnt++;
         $error("R ready outside the refill state or not held to the last beat");
      end

   // One tag set cleared per cycle
   boot_len: assert property (@(posedge clk)
      $rose(i_rst_n) |-> (i_state == ST_BOOT) [*16] ##1 (i_state != ST_BOOT))
      else
      begin
         fail_cnt++;
         $error("Boot sweep did not last 16 cycles");
      end

endmodule

bind icache_refill_ctrl icache_properties u_props (
   .clk        (clk),
   .i_rst_n    (i_rst_n),
   .i_state    (state_q),
   .i_ar_valid (o_ar_valid),
   .i_ar_addr  (o_ar_addr),
   .i_ar_ready (i_ar_ready),
   .i_r_valid  (i_r_valid),
   .i_r_last   (i_r_last),
   .i_r_ready  (o_r_ready)
);

`default_nettype wire

// ==== sim/icache_tb.sv ====
/*
 * Instruction cache testbench
 * Drives fetch and invalidate traffic into icache_top, answers refills
 * with an AXI read memory model, and checks every returned word and
 * every refill burst against a reference memory function
 */
`timescale 1ns/1ns
`default_nettype none

`include "icache_consts.svh"

module icache_tb;

   import icache_pkg::*;

   localparam int WAIT_LIMIT = 200;   // Cycles any single wait may take

   logic                  clk;
   logic                  i_rst_n;
   logic                  i_fetch_valid;
   ic_addr_u              i_fetch_addr;
   logic                  o_stall;
   ic_word_t              o_ins;
   logic                  o_ins_valid;
   logic                  i_inv_we;
   ic_addr_u              i_inv_addr;
   logic                  o_ar_valid;
   logic [`IC_ADDR_W-1:0] o_ar_addr;
   logic [7:0]            o_ar_len;
   logic                  i_ar_ready;
   logic                  i_r_valid;
   ic_word_t              i_r_data;
   logic                  i_r_last;
   logic                  o_r_ready;

   ic_addr_u    stim_q[$];     // Fetches still to be driven
   ic_addr_u    exp_q[$];      // Accepted fetches awaiting a result
   int          acc_q[$];      // Edge on which each fetch was accepted
   ic_addr_u    ar_q[$];       // Bursts requested by the DUT
   ic_addr_u    exp_ar_q[$];
   int          cyc = 0;
   int          stall_cycles;
   logic        check_lat = 1'b0;
   string       test_name = "init";
   int          data_errs = 0;
   int          addr_errs = 0;
   int          other_errs = 0;
   logic [31:0] stim_lfsr = 32'h7eed_169e;
   logic [31:0] mem_lfsr = 32'h7eed_169e;
   ic_addr_u    mon_addr;
   int          mon_edge;

   icache_top dut0 (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_fetch_valid (i_fetch_valid),
      .i_fetch_addr  (i_fetch_addr),
      .o_stall       (o_stall),
      .o_ins         (o_ins),
      .o_ins_valid   (o_ins_valid),
      .i_inv_we      (i_inv_we),
      .i_inv_addr    (i_inv_addr),
      .o_ar_valid    (o_ar_valid),
      .o_ar_addr     (o_ar_addr),
      .o_ar_len      (o_ar_len),
      .i_ar_ready    (i_ar_ready),
      .i_r_valid     (i_r_valid),
      .i_r_data      (i_r_data),
      .i_r_last      (i_r_last),
      .o_r_ready     (o_r_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   // Memory contents: aligned word address folded with a constant
   function automatic ic_word_t mem_word(input logic [`IC_ADDR_W-1:0] a);
      mem_word = {32'h0, a[31:3], 3'b000} ^ 64'h5a17_c3e9_0f2d_b486;
   endfunction

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(inout logic [31:0] st, input int n, output int v);
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         v = (v << 1) | int'(st[0]);
         st = lfsr_next(st);
      end
   endtask

   function automatic ic_addr_u word_addr(input int tag, input int set, input int word);
      ic_addr_u a;
      a.fields.tag      = `IC_TAG_W'(tag);
      a.fields.set      = `IC_P_SETS'(set);
      a.fields.word     = `IC_P_BEATS'(word);
      a.fields.byte_off = '0;
      word_addr = a;
   endfunction

   task automatic check_word(input string name, input ic_word_t exp, input ic_word_t act);
      if (act !== exp)
      begin
         data_errs++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input ic_addr_u exp, input ic_addr_u act);
      if (act !== exp)
      begin
         addr_errs++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_len(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
      begin
         addr_errs++;
         $display("[FAIL] %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_counts();
      $display("Errors: data %0d, address %0d, other %0d, assertion %0d",
               data_errs, addr_errs, other_errs, dut0.u_ctrl.u_props.fail_cnt);
   endtask

   task automatic abort_run(input string why);
      $display("Timeout: %s", why);
      report_counts();
      $display("Simulation failed");
      $finish;
   endtask

   // Drive the queued fetches, each held until o_stall lets it in
   task automatic run_stream();
      ic_addr_u a;
      int       waited;
      stall_cycles = 0;
      while (stim_q.size() > 0)
      begin
         a             = stim_q.pop_front();
         i_fetch_valid = 1'b1;
         i_fetch_addr  = a;
         waited        = 0;
         while (o_stall && waited < WAIT_LIMIT)
         begin
            @(negedge clk);
            waited++;
         end
         if (o_stall)
            abort_run("fetch never accepted, o_stall stuck high");
         stall_cycles += waited;
         exp_q.push_back(a);
         acc_q.push_back(cyc + 1);   // Taken on the coming rising edge
         @(negedge clk);
      end
      i_fetch_valid = 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() > 0 && waited < WAIT_LIMIT)
      begin
         @(posedge clk);
         waited++;
      end
      if (exp_q.size() > 0)
         abort_run("instruction results still outstanding");
      @(negedge clk);
   endtask

   task automatic check_bursts();
      if (ar_q.size() != exp_ar_q.size())
      begin
         other_errs++;
         $display("%s: %0d AR bursts seen where %0d were expected",
                  test_name, ar_q.size(), exp_ar_q.size());
      end
      while (ar_q.size() > 0 && exp_ar_q.size() > 0)
         check_addr(test_name, exp_ar_q.pop_front(), ar_q.pop_front());
      ar_q.delete();
      exp_ar_q.delete();
   endtask

   task automatic invalidate_line(input ic_addr_u a);
      int waited;
      waited = 0;
      while (o_stall && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (o_stall)
         abort_run("cache never idle for the invalidate");
      i_inv_we   = 1'b1;
      i_inv_addr = a;
      @(negedge clk);
      i_inv_we = 1'b0;
      if (!o_stall)
      begin
         other_errs++;
         $display("%s: o_stall did not rise for the invalidate", test_name);
      end
      @(negedge clk);
      if (o_stall)
      begin
         other_errs++;
         $display("%s: o_stall stayed high past the invalidate cycle", test_name);
      end
   endtask

   // Compare process for returned instructions
   always @(negedge clk)
   begin
      if (i_rst_n && o_ins_valid)
      begin
         if (exp_q.size() == 0)
         begin
            other_errs++;
            $display("%s: o_ins_valid with no fetch outstanding", test_name);
         end
         else
         begin
            mon_addr = exp_q.pop_front();
            mon_edge = acc_q.pop_front();
            check_word(test_name, mem_word(mon_addr), o_ins);
            if (check_lat && (cyc + 1 - mon_edge) != 2)
            begin
               other_errs++;
               $display("%s: word for %h arrived %0d edges after acceptance instead of 2",
                        test_name, mon_addr, cyc + 1 - mon_edge);
            end
         end
      end
   end

   // AXI read memory model, random gaps before AR ready and each beat
   initial
   begin : axi_mem
      logic [`IC_ADDR_W-1:0] burst;
      int                    delay;
      int                    waited;
      i_ar_ready = 1'b0;
      i_r_valid  = 1'b0;
      i_r_data   = '0;
      i_r_last   = 1'b0;
      forever
      begin
         @(negedge clk);
         if (i_rst_n && o_ar_valid)
         begin
            take_bits(mem_lfsr, 2, delay);
            repeat (delay) @(negedge clk);
            i_ar_ready = 1'b1;
            burst      = o_ar_addr;
            ar_q.push_back(burst);
            check_len(test_name, 8'd3, o_ar_len);   // Four beats per line
            @(negedge clk);
            i_ar_ready = 1'b0;
            for (int b = 0; b < `IC_BEATS; b++)
            begin
               take_bits(mem_lfsr, 2, delay);
               repeat (delay) @(negedge clk);
               i_r_valid = 1'b1;
               i_r_data  = mem_word(burst + `IC_ADDR_W'(b * 8));
               i_r_last  = (b == `IC_BEATS - 1);
               waited    = 0;
               while (!o_r_ready && waited < WAIT_LIMIT)
               begin
                  @(negedge clk);
                  waited++;
               end
               if (!o_r_ready)
                  abort_run("o_r_ready never rose for a read beat");
               @(negedge clk);   // Beat taken on the edge in between
               i_r_valid = 1'b0;
               i_r_last  = 1'b0;
            end
         end
      end
   end

   initial
   begin : main
      int       boot_cycles;
      logic     ar_in_boot;
      int       order [`IC_BEATS];
      int       pick;
      int       tmp;
      i_rst_n       = 1'b0;
      i_fetch_valid = 1'b0;
      i_fetch_addr  = '0;
      i_inv_we      = 1'b0;
      i_inv_addr    = '0;

      if ($bits(ic_addr_u) != `IC_ADDR_W || $bits(ic_tag_entry_t) != `IC_TAG_W + 1)
      begin
         other_errs++;
         $display("Address union or tag entry has the wrong width");
      end
      if (`IC_TAG_W != 23 || `IC_BEATS != 4)
      begin
         other_errs++;
         $display("Cache geometry does not give a 23-bit tag and 4-beat lines");
      end

      repeat (8) @(negedge clk);
      i_rst_n = 1'b1;

      test_name = "boot";
      if (o_ar_valid || o_r_ready || o_ins_valid)
      begin
         other_errs++;
         $display("boot: AXI or result outputs active right after reset");
      end
      boot_cycles = 0;
      ar_in_boot  = 1'b0;
      while (o_stall && boot_cycles < WAIT_LIMIT)
      begin
         ar_in_boot |= o_ar_valid;
         boot_cycles++;
         @(negedge clk);
      end
      if (boot_cycles != 16 || ar_in_boot)
      begin
         other_errs++;
         $display("boot: stall lasted %0d cycles (16 expected), AR during boot %0b",
                  boot_cycles, ar_in_boot);
      end

      // One new line per set, each a single burst
      test_name = "first_fill";
      for (int s = 0; s < `IC_SETS; s++)
      begin
         stim_q.push_back(word_addr(32'h1000 + s, s, s % `IC_BEATS));
         exp_ar_q.push_back(word_addr(32'h1000 + s, s, 0));
         run_stream();
         drain();
         check_bursts();
      end

      test_name = "refetch";
      check_lat = 1'b1;
      for (int s = 0; s < `IC_SETS; s++)
         for (int w = 0; w < `IC_BEATS; w++)
            stim_q.push_back(word_addr(32'h1000 + s, s, w));
      run_stream();
      drain();
      check_lat = 1'b0;
      if (stall_cycles != 0)
      begin
         other_errs++;
         $display("refetch: hits stalled for %0d cycles", stall_cycles);
      end
      check_bursts();

      // Second line in sets 0..3, words in shuffled order
      test_name = "random_order";
      for (int s = 0; s < 4; s++)
      begin
         for (int w = 0; w < `IC_BEATS; w++)
            order[w] = w;
         for (int i = `IC_BEATS - 1; i > 0; i--)
         begin
            take_bits(stim_lfsr, 2, pick);
            pick        = pick % (i + 1);
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
         end
         for (int w = 0; w < `IC_BEATS; w++)
            stim_q.push_back(word_addr(32'h2000 + s, s, order[w]));
         exp_ar_q.push_back(word_addr(32'h2000 + s, s, 0));
      end
      run_stream();
      drain();
      check_bursts();

      // Lines that are surely resident, set 4 never refilled, set 1 filled last
      test_name = "invalidate";
      invalidate_line(word_addr(32'h1002, 2, 0));
      stim_q.push_back(word_addr(32'h1002, 2, 3));
      exp_ar_q.push_back(word_addr(32'h1002, 2, 0));
      for (int w = 0; w < `IC_BEATS; w++)
      begin
         stim_q.push_back(word_addr(32'h1004, 4, w));
         stim_q.push_back(word_addr(32'h2001, 1, w));
      end
      run_stream();
      drain();
      check_bursts();

      // Three tags fighting over set 5, data only
      test_name = "set_conflict";
      for (int r = 0; r < 4; r++)
         for (int t = 0; t < 3; t++)
         begin
            take_bits(stim_lfsr, 2, pick);
            stim_q.push_back(word_addr(32'h3005 + t * 32'h1000, 5, pick));
         end
      run_stream();
      drain();
      ar_q.delete();

      repeat (4) @(negedge clk);
      report_counts();
      if (data_errs + addr_errs + other_errs + dut0.u_ctrl.u_props.fail_cnt == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_lookup.sv
hdl/icache_refill_ctrl.sv
hdl/icache_payload_result.sv
hdl/icache_top.sv
sim/icache_properties.sv
sim/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/icache_pkg.sv
      - hdl/icache_tag_lookup.sv
      - hdl/icache_refill_ctrl.sv
      - hdl/icache_payload_result.sv
      - hdl/icache_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/icache_properties.sv
      - sim/icache_tb.sv
